//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --assert -j 0
TOP       := tb_rv32_core
FILELIST  := rv32_core.f

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM     := obj_dir/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx '\*\* PASS \*\*'

clean:
	rm -rf obj_dir

//--- rv32_core.f
source/rv_isa_pkg.sv
source/core_ctrl_pkg.sv
source/fetch_unit.sv
source/register_file.sv
source/instr_decoder.sv
source/execute_unit.sv
source/rv32_core.sv
testbench/rv32_core_assert.sv
testbench/tb_rv32_core.sv

//--- source/core_ctrl_pkg.sv
// --------------------------------------
// control passed between pipeline stages
// addresses and targets are carried at xlen
// and cut to the pc width in execute
// --------------------------------------
package core_ctrl_pkg;
    import rv_isa_pkg::*;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_srl,
        alu_sra,
        alu_and,
        alu_or,
        alu_xor
    } alu_op_e;

    typedef enum logic [1:0] {
        sel0_rs1,
        sel0_zero,
        sel0_slt,
        sel0_sltu
    } alu_sel0_e;

    typedef enum logic [3:0] {
        br_jal,
        br_jalr,
        br_beq,
        br_bne,
        br_blt,
        br_bge,
        br_bltu,
        br_bgeu
    } branch_sel_e;

    typedef struct packed {
        logic            valid;
        logic            rd_en;        // already false for x0
        ridx_t           rd_idx;
        logic            rs1_en;
        logic            rs2_en;
        logic            rs1_fwd;
        logic            rs2_fwd;
        alu_op_e         alu_op;
        alu_sel0_e       alu_sel0;
        logic            alu_use_imm;
        logic [xlen-1:0] alu_imm;
        logic            branch_en;
        branch_sel_e     branch_sel;
        logic [xlen-1:0] branch_pc;    // jalr holds the offset only
        logic            store_en;
        logic [xlen-1:0] store_ofs;
        logic            cmp_use_imm;  // slti / sltiu
        logic [xlen-1:0] cmp_imm;
    } dec_ctrl_t;

    typedef struct packed {
        logic            valid;
        ridx_t           rd;
        logic [xlen-1:0] value;
    } wb_t;

    typedef struct packed {
        logic            wr;
        logic [xlen-1:0] addr;
        logic [xlen-1:0] data;
    } store_t;

endpackage

//--- source/execute_unit.sv
`timescale 1ns/1ps
// --------------------------------------
// execute stage
// redirect and store are combinational,
// writeback is registered and also feeds
// the one-deep forward path
// --------------------------------------
module execute_unit
    import rv_isa_pkg::*;
    import core_ctrl_pkg::*;
#(
    parameter int pc_width = 14
) (
    input  logic                clk,
    input  logic                reset,
    input  dec_ctrl_t           dec_i,
    input  logic [xlen-1:0]     rs1_val_i,
    input  logic [xlen-1:0]     rs2_val_i,
    output logic                redirect_o,
    output logic [pc_width-1:0] redirect_pc_o,
    output store_t              store_o,
    output wb_t                 wb_o
);
    localparam int shamt_w = $clog2(xlen);

    logic [xlen-1:0] rs1;
    logic [xlen-1:0] rs2;
    logic [xlen-1:0] cmp_b;
    logic [xlen-1:0] diff;
    logic            carry;
    logic            overflow;
    logic            zero;
    logic            lt;
    logic            ltu;
    logic            cond;
    logic [xlen-1:0] target;
    logic [xlen-1:0] alu_in0;
    logic [xlen-1:0] alu_in1;
    logic [xlen-1:0] alu_res;

    // --------------------------------------
    // operands
    assign rs1 = !dec_i.rs1_en ? '0 : dec_i.rs1_fwd ? wb_o.value : rs1_val_i;
    assign rs2 = !dec_i.rs2_en ? '0 : dec_i.rs2_fwd ? wb_o.value : rs2_val_i;

    // one subtractor for branches and slt
    assign cmp_b         = dec_i.cmp_use_imm ? dec_i.cmp_imm : rs2;
    assign {carry, diff} = {1'b0, rs1} + {1'b0, ~cmp_b} + (xlen + 1)'(1);
    assign overflow      = (rs1[xlen-1] != cmp_b[xlen-1]) && (diff[xlen-1] != rs1[xlen-1]);
    assign zero          = (diff == '0);
    assign lt            = diff[xlen-1] ^ overflow;
    assign ltu           = !carry;   // no carry out means borrow

    // --------------------------------------
    // branch resolution
    always_comb begin
        case (dec_i.branch_sel)
            br_jal, br_jalr: cond = 1'b1;
            br_beq:          cond = zero;
            br_bne:          cond = !zero;
            br_blt:          cond = lt;
            br_bge:          cond = !lt;
            br_bltu:         cond = ltu;
            br_bgeu:         cond = !ltu;
            default:         cond = 1'b0;
        endcase
    end

    assign target        = (dec_i.branch_sel == br_jalr)
                           ? ((rs1 + dec_i.branch_pc) & ~xlen'(1)) : dec_i.branch_pc;
    assign redirect_o    = dec_i.valid && dec_i.branch_en && cond;
    assign redirect_pc_o = target[pc_width-1:0];

    // --------------------------------------
    // ALU
    always_comb begin
        case (dec_i.alu_sel0)
            sel0_rs1:  alu_in0 = rs1;
            sel0_zero: alu_in0 = '0;
            sel0_slt:  alu_in0 = xlen'(lt);
            default:   alu_in0 = xlen'(ltu);
        endcase
        alu_in1 = dec_i.alu_use_imm ? dec_i.alu_imm : rs2;
        case (dec_i.alu_op)
            alu_add: alu_res = alu_in0 + alu_in1;
            alu_sub: alu_res = alu_in0 - alu_in1;
            alu_sll: alu_res = alu_in0 << alu_in1[shamt_w-1:0];
            alu_srl: alu_res = alu_in0 >> alu_in1[shamt_w-1:0];
            alu_sra: alu_res = $signed(alu_in0) >>> alu_in1[shamt_w-1:0];
            alu_and: alu_res = alu_in0 & alu_in1;
            alu_or:  alu_res = alu_in0 | alu_in1;
            default: alu_res = alu_in0 ^ alu_in1;
        endcase
    end

    // sw only, word strobe
    assign store_o.wr   = dec_i.valid && dec_i.store_en;
    assign store_o.addr = rs1 + dec_i.store_ofs;
    assign store_o.data = rs2;

    always_ff @(posedge clk) begin
        if (reset) begin
            wb_o.valid <= 1'b0;
        end else begin
            wb_o.valid <= dec_i.valid && dec_i.rd_en;
        end
        wb_o.rd    <= dec_i.rd_idx;
        wb_o.value <= alu_res;
    end

endmodule

//--- source/fetch_unit.sv
`timescale 1ns/1ps
// --------------------------------------
// program counter and fetch tag
// instruction memory reads with one cycle latency
// --------------------------------------
module fetch_unit #(
    parameter int                  pc_width = 14,
    parameter logic [pc_width-1:0] init_pc  = '0
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                redirect_i,
    input  logic [pc_width-1:0] redirect_pc_i,
    output logic [pc_width-1:0] ibus_addr_o,
    output logic [pc_width-1:0] fetch_pc_o,
    output logic                fetch_valid_o
);
    logic [pc_width-1:0] pc;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= init_pc;
        end else if (redirect_i) begin
            pc <= redirect_pc_i;
        end else begin
            pc <= pc + pc_width'(4);
        end
    end

    // tag for the word arriving on instr_i next cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            fetch_valid_o <= 1'b0;
        end else begin
            fetch_valid_o <= !redirect_i;   // word fetched in redirect cycle is stale
        end
        fetch_pc_o <= pc;
    end

    assign ibus_addr_o = pc;

endmodule

//--- source/instr_decoder.sv
`timescale 1ns/1ps
// --------------------------------------
// decode stage, bundle registered each edge
// forward flags compare against the bundle held
// here, which is the instruction now in execute
// --------------------------------------
module instr_decoder
    import rv_isa_pkg::*;
    import core_ctrl_pkg::*;
#(
    parameter int pc_width = 14
) (
    input  logic                clk,
    input  logic                reset,
    input  instr_u              instr_i,
    input  logic [pc_width-1:0] fetch_pc_i,
    input  logic                fetch_valid_i,
    input  logic                redirect_i,
    output dec_ctrl_t           dec_o
);
    logic [xlen-1:0] imm_i;
    logic [xlen-1:0] imm_s;
    logic [xlen-1:0] imm_b;
    logic [xlen-1:0] imm_j;
    logic [xlen-1:0] pc_x;
    dec_ctrl_t       dec_next;

    assign imm_i = {{20{instr_i.i.imm[11]}}, instr_i.i.imm};
    assign imm_s = {{20{instr_i.s.imm_hi[6]}}, instr_i.s.imm_hi, instr_i.s.imm_lo};
    assign imm_b = {{20{instr_i.b.imm_12}}, instr_i.b.imm_11, instr_i.b.imm_10_5,
                    instr_i.b.imm_4_1, 1'b0};
    assign imm_j = {{12{instr_i.j.imm_20}}, instr_i.j.imm_19_12, instr_i.j.imm_11,
                    instr_i.j.imm_10_1, 1'b0};
    assign pc_x  = xlen'(fetch_pc_i);

    always_comb begin
        dec_next             = '0;
        dec_next.valid       = fetch_valid_i && !redirect_i;
        dec_next.rd_idx      = instr_i.r.rd;
        dec_next.alu_use_imm = 1'b1;
        dec_next.alu_imm     = imm_i;
        dec_next.store_ofs   = imm_s;
        dec_next.cmp_imm     = imm_i;

        case (instr_i.r.opcode)
            op_lui: begin
                dec_next.rd_en    = 1'b1;
                dec_next.alu_sel0 = sel0_zero;
                dec_next.alu_imm  = {instr_i.u.imm, 12'b0};
            end
            op_jal, op_jalr: begin
                dec_next.rd_en      = 1'b1;
                dec_next.alu_sel0   = sel0_zero;
                dec_next.alu_imm    = pc_x + xlen'(4);   // link value
                dec_next.branch_en  = 1'b1;
                if (instr_i.r.opcode == op_jal) begin
                    dec_next.branch_sel = br_jal;
                    dec_next.branch_pc  = pc_x + imm_j;
                end else begin
                    dec_next.rs1_en     = 1'b1;
                    dec_next.branch_sel = br_jalr;
                    dec_next.branch_pc  = imm_i;   // rs1 added in execute
                end
            end
            op_branch: begin
                dec_next.rs1_en    = 1'b1;
                dec_next.rs2_en    = 1'b1;
                dec_next.branch_en = 1'b1;
                dec_next.branch_pc = pc_x + imm_b;
                case (instr_i.r.funct3)
                    3'b000:  dec_next.branch_sel = br_beq;
                    3'b001:  dec_next.branch_sel = br_bne;
                    3'b100:  dec_next.branch_sel = br_blt;
                    3'b101:  dec_next.branch_sel = br_bge;
                    3'b110:  dec_next.branch_sel = br_bltu;
                    3'b111:  dec_next.branch_sel = br_bgeu;
                    default: dec_next.branch_en  = 1'b0;
                endcase
            end
            op_store: begin
                dec_next.rs1_en   = 1'b1;
                dec_next.rs2_en   = 1'b1;
                dec_next.store_en = (instr_i.r.funct3 == 3'b010);   // sw only
            end
            op_imm, op_reg: begin
                dec_next.rd_en       = 1'b1;
                dec_next.rs1_en      = 1'b1;
                dec_next.rs2_en      = (instr_i.r.opcode == op_reg);
                dec_next.alu_use_imm = (instr_i.r.opcode == op_imm);
                dec_next.cmp_use_imm = (instr_i.r.opcode == op_imm);
                case (instr_i.r.funct3)
                    3'b000: dec_next.alu_op = (dec_next.rs2_en && instr_i.r.funct7[5])
                                              ? alu_sub : alu_add;
                    3'b001: dec_next.alu_op = alu_sll;
                    3'b010, 3'b011: begin
                        // flag plus zero
                        dec_next.alu_sel0    = instr_i.r.funct3[0] ? sel0_sltu : sel0_slt;
                        dec_next.alu_use_imm = 1'b1;
                        dec_next.alu_imm     = '0;
                    end
                    3'b100: dec_next.alu_op = alu_xor;
                    3'b101: dec_next.alu_op = instr_i.r.funct7[5] ? alu_sra : alu_srl;
                    3'b110: dec_next.alu_op = alu_or;
                    default: dec_next.alu_op = alu_and;
                endcase
            end
            default: ;
        endcase

        dec_next.rd_en   = dec_next.rd_en && (instr_i.r.rd != '0);
        dec_next.rs1_fwd = dec_o.valid && dec_o.rd_en && dec_next.rs1_en
                           && (dec_o.rd_idx == instr_i.r.rs1);
        dec_next.rs2_fwd = dec_o.valid && dec_o.rd_en && dec_next.rs2_en
                           && (dec_o.rd_idx == instr_i.r.rs2);
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            dec_o.valid <= 1'b0;
        end else begin
            dec_o <= dec_next;
        end
    end

endmodule

//--- source/register_file.sv
`timescale 1ns/1ps
// --------------------------------------
// 32 x xlen registers, synchronous reads
// a read on the write edge returns the new value
// x0 reads as zero
// --------------------------------------
module register_file
    import rv_isa_pkg::*;
    import core_ctrl_pkg::*;
(
    input  logic            clk,
    input  ridx_t           rs1_idx_i,
    input  ridx_t           rs2_idx_i,
    input  wb_t             wb_i,
    output logic [xlen-1:0] rs1_val_o,
    output logic [xlen-1:0] rs2_val_o
);
    logic [xlen-1:0] regs [32];

    function automatic logic [xlen-1:0] read_port(ridx_t idx);
        if (idx == '0) begin
            return '0;
        end else if (wb_i.valid && wb_i.rd == idx) begin
            return wb_i.value;   // write-first
        end
        return regs[idx];
    endfunction

    always_ff @(posedge clk) begin
        if (wb_i.valid) begin
            regs[wb_i.rd] <= wb_i.value;
        end
        rs1_val_o <= read_port(rs1_idx_i);
        rs2_val_o <= read_port(rs2_idx_i);
    end

endmodule

//--- source/rv32_core.sv
`timescale 1ns/1ps
// --------------------------------------
// three stage RV32I core, top level
// ALU ops, jumps, branches and sw only
// instr_i answers ibus_addr_o one cycle later
// --------------------------------------
module rv32_core
    import rv_isa_pkg::*;
    import core_ctrl_pkg::*;
#(
    parameter int                  pc_width = 14,
    parameter logic [pc_width-1:0] init_pc  = '0
) (
    input  logic                clk,
    input  logic                reset,
    output logic [pc_width-1:0] ibus_addr_o,
    input  instr_u              instr_i,
    output store_t              store_o,
    output wb_t                 wb_o
);
    logic                redirect;
    logic [pc_width-1:0] redirect_pc;
    logic [pc_width-1:0] fetch_pc;
    logic                fetch_valid;
    dec_ctrl_t           dec;
    logic [xlen-1:0]     rs1_val;
    logic [xlen-1:0]     rs2_val;

    fetch_unit #(
        .pc_width (pc_width),
        .init_pc  (init_pc)
    ) fetch_unit_inst (
        .clk           (clk),
        .reset         (reset),
        .redirect_i    (redirect),
        .redirect_pc_i (redirect_pc),
        .ibus_addr_o   (ibus_addr_o),
        .fetch_pc_o    (fetch_pc),
        .fetch_valid_o (fetch_valid)
    );

    // read indices taken straight off the returning word
    register_file register_file_inst (
        .clk       (clk),
        .rs1_idx_i (instr_i.r.rs1),
        .rs2_idx_i (instr_i.r.rs2),
        .wb_i      (wb_o),
        .rs1_val_o (rs1_val),
        .rs2_val_o (rs2_val)
    );

    instr_decoder #(
        .pc_width (pc_width)
    ) instr_decoder_inst (
        .clk           (clk),
        .reset         (reset),
        .instr_i       (instr_i),
        .fetch_pc_i    (fetch_pc),
        .fetch_valid_i (fetch_valid),
        .redirect_i    (redirect),
        .dec_o         (dec)
    );

    execute_unit #(
        .pc_width (pc_width)
    ) execute_unit_inst (
        .clk           (clk),
        .reset         (reset),
        .dec_i         (dec),
        .rs1_val_i     (rs1_val),
        .rs2_val_i     (rs2_val),
        .redirect_o    (redirect),
        .redirect_pc_o (redirect_pc),
        .store_o       (store_o),
        .wb_o          (wb_o)
    );

endmodule

//--- source/rv_isa_pkg.sv
// --------------------------------------
// RV32I encoding as seen by the core
// only opcodes the core executes are listed
// --------------------------------------
package rv_isa_pkg;

    localparam int xlen = 32;

    typedef logic [4:0] ridx_t;

    typedef enum logic [6:0] {
        op_lui    = 7'b0110111,
        op_jal    = 7'b1101111,
        op_jalr   = 7'b1100111,
        op_branch = 7'b1100011,
        op_store  = 7'b0100011,
        op_imm    = 7'b0010011,
        op_reg    = 7'b0110011
    } opcode_e;

    typedef struct packed {
        logic [6:0] funct7;
        ridx_t      rs2;
        ridx_t      rs1;
        logic [2:0] funct3;
        ridx_t      rd;
        opcode_e    opcode;
    } instr_r_t;

    typedef struct packed {
        logic [11:0] imm;
        ridx_t       rs1;
        logic [2:0]  funct3;
        ridx_t       rd;
        opcode_e     opcode;
    } instr_i_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        ridx_t      rs2;
        ridx_t      rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        opcode_e    opcode;
    } instr_s_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        ridx_t      rs2;
        ridx_t      rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        opcode_e    opcode;
    } instr_b_t;

    typedef struct packed {
        logic [19:0] imm;
        ridx_t       rd;
        opcode_e     opcode;
    } instr_u_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        ridx_t      rd;
        opcode_e    opcode;
    } instr_j_t;

    // one fetched word, viewed per format
    typedef union packed {
        logic [31:0] raw;
        instr_r_t    r;
        instr_i_t    i;
        instr_s_t    s;
        instr_b_t    b;
        instr_u_t    u;
        instr_j_t    j;
    } instr_u;

endpackage

//--- testbench/rv32_core_assert.sv
`timescale 1ns/1ps
// ----------------------------------------
// protocol checks for rv32_core, bound in
// redirect and redirect_pc are core internals
// ----------------------------------------
module rv32_core_assert
    import core_ctrl_pkg::*;
#(
    parameter int pc_width = 14
) (
    input logic                clk,
    input logic                reset,
    input logic [pc_width-1:0] ibus_addr_i,
    input logic                redirect_i,
    input logic [pc_width-1:0] redirect_pc_i,
    input store_t              store_i,
    input wb_t                 wb_i
);
    // quiet outputs once a reset edge has been seen
    quiet_in_reset: assert property (@(posedge clk)
        $past(reset) |-> !wb_i.valid && !store_i.wr)
        else $error("writeback or store active during reset");

    seq_fetch: assert property (@(posedge clk) disable iff (reset)
        !$past(reset) && !$past(redirect_i)
        |-> ibus_addr_i == pc_width'($past(ibus_addr_i) + pc_width'(4)))
        else $error("fetch address did not advance by 4");

    redirect_fetch: assert property (@(posedge clk) disable iff (reset)
        !$past(reset) && $past(redirect_i) |-> ibus_addr_i == $past(redirect_pc_i))
        else $error("fetch address is not the redirect target");

    no_x0_write: assert property (@(posedge clk) disable iff (reset)
        wb_i.valid |-> wb_i.rd != 5'd0)
        else $error("writeback names x0");

endmodule

bind rv32_core rv32_core_assert #(
    .pc_width (pc_width)
) rv32_core_assert_inst (
    .clk           (clk),
    .reset         (reset),
    .ibus_addr_i   (ibus_addr_o),
    .redirect_i    (redirect),
    .redirect_pc_i (redirect_pc),
    .store_i       (store_o),
    .wb_i          (wb_o)
);

//--- testbench/tb_rv32_core.sv
`timescale 1ns/1ps
// ----------------------------------------
// testbench for rv32_core
// program built at start, model runs it in order
// rom holds 256 words, events checked at negedge
// ----------------------------------------
module tb_rv32_core
    import rv_isa_pkg::*;
    import core_ctrl_pkg::*;
;
    localparam logic [31:0] halt_word = 32'h0000006f;   // jal x0, 0

    logic        clk;
    logic        reset;
    logic [13:0] ibus_addr;
    instr_u      instr;
    store_t      store;
    wb_t         wb;

    logic [31:0] rom [256];
    int          rom_test [256];
    int          prog_len;
    int          cur_test;
    logic [13:0] last_addr;
    int          cycles;
    int          limit;
    bit          verdict_printed;

    string       test_name [6] = '{"reset_fetch", "alu", "forwarding", "branches",
                                   "jumps", "stores"};
    int          remaining [6];
    int          test_err [6];
    int          errors;
    int          tests_failed;

    int          exp_wb_rd [$];
    logic [31:0] exp_wb_val [$];
    int          exp_wb_test [$];
    logic [31:0] exp_st_addr [$];
    logic [31:0] exp_st_data [$];
    int          exp_st_test [$];

    rv32_core #(
        .pc_width (14),
        .init_pc  (14'd0)
    ) rv32_core_inst (
        .clk         (clk),
        .reset       (reset),
        .ibus_addr_o (ibus_addr),
        .instr_i     (instr),
        .store_o     (store),
        .wb_o        (wb)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ----------------------------------------
    // encoders
    function automatic logic [31:0] enc_r(logic f7b5, int rs2, int rs1, logic [2:0] f3, int rd);
        return {1'b0, f7b5, 5'd0, 5'(rs2), 5'(rs1), f3, 5'(rd), 7'h33};
    endfunction

    function automatic logic [31:0] enc_i(logic [11:0] imm, int rs1, logic [2:0] f3, int rd,
                                          logic [6:0] op);
        return {imm, 5'(rs1), f3, 5'(rd), op};
    endfunction

    function automatic logic [31:0] enc_s(logic [11:0] imm, int rs2, int rs1);
        return {imm[11:5], 5'(rs2), 5'(rs1), 3'b010, imm[4:0], 7'h23};
    endfunction

    function automatic logic [31:0] enc_b(logic [12:0] imm, int rs2, int rs1, logic [2:0] f3);
        return {imm[12], imm[10:5], 5'(rs2), 5'(rs1), f3, imm[4:1], imm[11], 7'h63};
    endfunction

    function automatic logic [31:0] enc_j(logic [20:0] imm, int rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], 5'(rd), 7'h6f};
    endfunction

    task automatic emit(logic [31:0] w);
        rom[prog_len]      = w;
        rom_test[prog_len] = cur_test;
        prog_len++;
    endtask

    task automatic build_program();
        logic [2:0] br_f3 [10] = '{3'd0, 3'd1, 3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7, 3'd4, 3'd6};
        int         br_a  [10] = '{1, 1, 1, 1, 1, 1, 1, 1, 2, 2};
        int         br_b  [10] = '{1, 1, 2, 2, 2, 2, 2, 2, 1, 1};
        int         p;
        for (int k = 0; k < 256; k++) begin
            rom[k]      = enc_i(12'(k), 0, 3'd0, 0, 7'h13);   // nop tagged by index
            rom_test[k] = 0;
        end
        prog_len = 0;
        cur_test = 1;   // alu
        emit({20'($urandom), 5'd1, 7'h37});
        emit({20'($urandom), 5'd2, 7'h37});
        emit(enc_i(12'($urandom), 0, 3'd0, 3, 7'h13));
        emit(enc_i(12'd0, 0, 3'd0, 0, 7'h13));
        emit(enc_i(12'd0, 0, 3'd0, 0, 7'h13));
        for (int f = 0; f < 8; f++) begin
            emit(enc_r(1'b0, 2, 1, 3'(f), 4 + f));
        end
        emit(enc_r(1'b1, 2, 1, 3'd0, 12));   // sub
        emit(enc_r(1'b1, 2, 1, 3'd5, 13));   // sra
        for (int f = 0; f < 8; f++) begin
            if (f == 1 || f == 5) begin
                emit(enc_i(12'($urandom & 31), 3, 3'(f), 4 + f, 7'h13));
            end else begin
                emit(enc_i(12'($urandom), 1, 3'(f), 4 + f, 7'h13));
            end
        end
        emit(enc_i({7'b0100000, 5'($urandom)}, 1, 3'd5, 13, 7'h13));   // srai
        cur_test = 2;   // back-to-back dependencies
        emit(enc_r(1'b0, 2, 1, 3'd0, 14));
        emit(enc_r(1'b0, 1, 14, 3'd0, 15));
        emit(enc_r(1'b1, 14, 15, 3'd0, 16));
        emit(enc_r(1'b0, 16, 1, 3'd4, 17));
        emit(enc_i(12'd5, 17, 3'd0, 18, 7'h13));
        emit(enc_r(1'b0, 16, 18, 3'd0, 19));
        emit(enc_r(1'b0, 18, 19, 3'd3, 20));
        cur_test = 3;   // each branch skips two words when taken
        emit(enc_i(12'd0, 0, 3'd0, 21, 7'h13));   // counters start at zero
        emit(enc_i(12'd0, 0, 3'd0, 22, 7'h13));
        for (int k = 0; k < 10; k++) begin
            emit(enc_b(13'd12, br_b[k], br_a[k], br_f3[k]));
            emit(enc_i(12'd1, 21, 3'd0, 21, 7'h13));
            emit(enc_s(12'd64, 21, 0));
            emit(enc_i(12'(k + 1), 22, 3'd0, 22, 7'h13));
        end
        cur_test = 4;
        emit(enc_j(21'd12, 23));
        emit(enc_i(12'd1, 24, 3'd0, 24, 7'h13));
        emit(enc_s(12'd32, 24, 0));
        emit(enc_i(12'd0, 23, 3'd0, 25, 7'h13));
        p = prog_len * 4;
        emit(enc_i(12'(p + 12), 0, 3'd0, 26, 7'h13));
        emit(enc_i(12'd4, 26, 3'd0, 27, 7'h67));   // jalr to p+16
        emit(enc_i(12'd1, 24, 3'd0, 24, 7'h13));
        emit(enc_s(12'd36, 24, 0));
        emit(enc_r(1'b0, 0, 27, 3'd0, 28));
        cur_test = 5;
        emit(enc_i(12'(($urandom & 255) << 2), 0, 3'd0, 29, 7'h13));
        emit(enc_s(12'd0, 1, 29));
        emit(enc_s(-12'sd8, 2, 29));
        emit(enc_r(1'b0, 3, 1, 3'd0, 30));
        emit(enc_s(12'd12, 30, 29));
        emit(enc_b(13'd12, 0, 0, 3'd0));
        emit(enc_s(12'd0, 1, 0));
        emit(enc_s(12'd4, 2, 0));
        emit(enc_s(12'd4, 3, 29));
        emit(halt_word);
    endtask

    // ----------------------------------------
    // reference model, program order
    task automatic run_model();
        logic [31:0] r [32];
        logic [31:0] w;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        logic [31:0] imm_i;
        logic [31:0] npc;
        logic [31:0] pc;
        logic        wr;
        logic        take;
        int          t;
        foreach (r[k]) r[k] = '0;
        pc = '0;
        for (int step = 0; step < 1000; step++) begin
            w = rom[pc[9:2]];
            if (w == halt_word) break;
            t     = rom_test[pc[9:2]];
            imm_i = {{20{w[31]}}, w[31:20]};
            a     = r[w[19:15]];
            npc   = pc + 4;
            wr    = 1'b0;
            res   = '0;
            case (w[6:0])
                7'h37: begin
                    res = {w[31:12], 12'd0};
                    wr  = 1'b1;
                end
                7'h6f: begin
                    res = pc + 4;
                    wr  = 1'b1;
                    npc = pc + {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
                end
                7'h67: begin
                    res = pc + 4;
                    wr  = 1'b1;
                    npc = (a + imm_i) & ~32'd1;
                end
                7'h63: begin
                    b = r[w[24:20]];
                    case (w[14:12])
                        3'd0:    take = a == b;
                        3'd1:    take = a != b;
                        3'd4:    take = $signed(a) < $signed(b);
                        3'd5:    take = $signed(a) >= $signed(b);
                        3'd6:    take = a < b;
                        default: take = a >= b;
                    endcase
                    if (take) npc = pc + {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
                end
                7'h23: begin
                    exp_st_addr.push_back(a + {{20{w[31]}}, w[31:25], w[11:7]});
                    exp_st_data.push_back(r[w[24:20]]);
                    exp_st_test.push_back(t);
                    remaining[t]++;
                end
                default: begin   // op-imm and op
                    b  = (w[6:0] == 7'h13) ? imm_i : r[w[24:20]];
                    wr = 1'b1;
                    case (w[14:12])
                        3'd0: res = (w[6:0] == 7'h33 && w[30]) ? a - b : a + b;
                        3'd1: res = a << b[4:0];
                        3'd2: res = 32'($signed(a) < $signed(b));
                        3'd3: res = 32'(a < b);
                        3'd4: res = a ^ b;
                        3'd5: res = w[30] ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
                        3'd6: res = a | b;
                        default: res = a & b;
                    endcase
                end
            endcase
            if (wr && w[11:7] != 5'd0) begin
                r[w[11:7]] = res;
                exp_wb_rd.push_back(int'(w[11:7]));
                exp_wb_val.push_back(res);
                exp_wb_test.push_back(t);
                remaining[t]++;
            end
            pc = npc;
        end
    endtask

    task automatic report_test(int t);
        if (test_err[t] != 0) tests_failed++;
        $display("test %-12s %s (%0d errors)", test_name[t],
                 test_err[t] == 0 ? "ok" : "failed", test_err[t]);
    endtask

    task automatic retire_event(int t);
        remaining[t]--;
        if (remaining[t] == 0) report_test(t);
    endtask

    // ----------------------------------------
    // rom answers one cycle later
    always @(negedge clk) last_addr <= ibus_addr;

    always @(posedge clk) begin
        #1;
        if ($isunknown(last_addr)) instr.raw = 32'h00000013;
        else instr.raw = rom[last_addr[9:2]];
    end

    always @(negedge clk) begin
        int t;
        if (!reset && wb.valid) begin
            if (exp_wb_rd.size() == 0) begin
                $display("unexpected writeback to x%0d after the program ended", wb.rd);
                errors++;
            end else begin
                t = exp_wb_test.pop_front();
                assert (wb.rd == 5'(exp_wb_rd[0]) && wb.value == exp_wb_val[0])
                else begin
                    $display("ERROR %s: expected x%0d=%08h, actual x%0d=%08h", test_name[t],
                             exp_wb_rd[0], exp_wb_val[0], wb.rd, wb.value);
                    test_err[t]++;
                    errors++;
                end
                void'(exp_wb_rd.pop_front());
                void'(exp_wb_val.pop_front());
                retire_event(t);
            end
        end
        if (!reset && store.wr) begin
            if (exp_st_addr.size() == 0) begin
                $display("unexpected store to %08h after the program ended", store.addr);
                errors++;
            end else begin
                t = exp_st_test.pop_front();
                assert (store.addr == exp_st_addr[0] && store.data == exp_st_data[0])
                else begin
                    $display("ERROR %s: expected store %08h@%08h, actual %08h@%08h",
                             test_name[t], exp_st_data[0], exp_st_addr[0],
                             store.data, store.addr);
                    test_err[t]++;
                    errors++;
                end
                void'(exp_st_addr.pop_front());
                void'(exp_st_data.pop_front());
                retire_event(t);
            end
        end
    end

    // run limit
    always @(posedge clk) begin
        cycles++;
        if (cycles >= limit) begin
            $display("timeout after %0d cycles with events still pending", cycles);
            verdict_printed = 1'b1;
            $display("** FAIL **");
            $finish;
        end
    end

    final begin
        if (!verdict_printed) $display("** FAIL **");
    end

    initial begin
        void'($urandom(32'hd1d6f0cf));
        reset     = 1'b1;
        instr.raw = 32'h00000013;
        cycles    = 0;
        limit     = 1000000;
        errors    = 0;
        foreach (remaining[k]) remaining[k] = 0;
        foreach (test_err[k]) test_err[k] = 0;
        build_program();
        run_model();
        limit = 4 * prog_len + 50;
        repeat (8) @(posedge clk);
        #1 reset = 1'b0;

        // reset_fetch, first writeback is due in cycle 3
        for (int k = 0; k < 4; k++) begin
            @(negedge clk);
            assert (ibus_addr == 14'(4 * k))
            else begin
                $display("ERROR %s: expected addr %0h, actual %0h", test_name[0], 4 * k,
                         ibus_addr);
                test_err[0]++;
                errors++;
            end
            assert (k == 3 || (!wb.valid && !(k < 2 && store.wr)))
            else begin
                $display("writeback or store seen before the first instruction executed");
                test_err[0]++;
                errors++;
            end
        end
        report_test(0);

        while (exp_wb_rd.size() != 0 || exp_st_addr.size() != 0) @(posedge clk);
        repeat (10) @(posedge clk);   // room for stray events
        $display("tests: %0d run, %0d failed, %0d errors", 6, tests_failed, errors);
        verdict_printed = 1'b1;
        if (errors == 0 && tests_failed == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule
